// ==== rtl/eeprom_params.svh ====
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Storage geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Number of byte locations
`define EE_DEPTH        2048

// Block select (3 bits) plus word address (8 bits)
`define EE_ADDR_W       11

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Upper nibble of a control byte that selects this device
`define EE_DEV_TYPE     4'b1010

// Flops per line in the input synchronizer, at least 2
`define EE_SYNC_STAGES  2

`endif

// ==== rtl/eeprom_pkg.sv ====
`default_nettype none

`include "eeprom_params.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0]            mem_data_t;
    typedef logic [7:0]            ctrl_byte_t;

    // Serial protocol engine
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_GET_CTRL,
        ST_ACK_CTRL,
        ST_GET_ADDR,
        ST_ACK_ADDR,
        ST_GET_DATA,
        ST_ACK_DATA,
        ST_SEND_DATA,
        ST_WAIT_MACK,
        ST_IGNORE
    } slave_state_t;

    typedef enum logic {
        OWN_SERIAL,
        OWN_HOST
    } arb_owner_t;

endpackage

`default_nettype wire

// ==== rtl/mem_port_if.sv ====
`default_nettype none

interface mem_port_if;

    import eeprom_pkg::*;

    logic      req;
    logic      we;
    mem_addr_t addr;
    mem_data_t wdata;
    logic      gnt;
    mem_data_t rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

`default_nettype wire

// ==== rtl/bus_line_sync.sv ====
`default_nettype none

`include "eeprom_params.svh"

module bus_line_sync (
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic data_in,
    output logic scl_s,
    output logic data_s,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det
);

    localparam int STAGES = `EE_SYNC_STAGES;

    logic [STAGES-1:0] scl_ff;
    logic [STAGES-1:0] data_ff;
    logic              scl_new;
    logic              data_new;

    assign scl_new  = scl_ff[STAGES-1];
    assign data_new = data_ff[STAGES-1];

    // Idle bus is high on both lines
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_ff    <= '1;
            data_ff   <= '1;
            scl_s     <= 1'b1;
            data_s    <= 1'b1;
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end
        else
        begin
            scl_ff    <= {scl_ff[STAGES-2:0], scl};
            data_ff   <= {data_ff[STAGES-2:0], data_in};
            scl_s     <= scl_new;
            data_s    <= data_new;
            scl_rise  <= scl_new && !scl_s;
            scl_fall  <= !scl_new && scl_s;
            // Data moves while the clock stays high
            start_det <= scl_new && scl_s && !data_new && data_s;
            stop_det  <= scl_new && scl_s && data_new && !data_s;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/serial_slave_fsm.sv ====
`default_nettype none

`include "eeprom_params.svh"

module serial_slave_fsm (
    input  logic          sda,
    input  logic          rst_n,
    input  logic          scl_rise,
    input  logic          scl_fall,
    input  logic          data_s,
    input  logic          start_det,
    input  logic          stop_det,
    output logic          data_pull,
    mem_port_if.requester mem
);

    import eeprom_pkg::*;

    slave_state_t state;
    slave_state_t get_next;
    slave_state_t ack_next;
    logic [2:0]   bit_cnt;
    mem_data_t    shift_q;
    mem_data_t    byte_in;
    ctrl_byte_t   ctrl_q;
    mem_data_t    word_addr;
    mem_data_t    wdata_q;
    mem_data_t    send_q;
    logic         byte_done;
    logic         ctrl_hit;
    logic         rd_launch;
    logic         wr_launch;
    logic         req_q;
    logic         we_q;
    logic         rd_wait;

    assign byte_in   = {shift_q[6:0], data_s};
    assign byte_done = scl_rise && (bit_cnt == 3'd7);
    assign ctrl_hit  = byte_done && (state == ST_GET_CTRL)
                       && (byte_in[7:4] == `EE_DEV_TYPE);
    assign rd_launch = ctrl_hit && byte_in[0];
    // Write goes out as soon as the ACK clock of the data byte starts
    assign wr_launch = scl_fall && (state == ST_ACK_DATA) && !data_pull;

    assign mem.req   = req_q;
    assign mem.we    = we_q;
    assign mem.addr  = {ctrl_q[3:1], word_addr};
    assign mem.wdata = wdata_q;

    always_comb
    begin
        get_next = ST_IDLE;
        ack_next = ST_IDLE;
        case (state)
            ST_GET_CTRL:
                get_next = (byte_in[7:4] == `EE_DEV_TYPE) ? ST_ACK_CTRL : ST_IGNORE;
            ST_GET_ADDR:
                get_next = ST_ACK_ADDR;
            ST_GET_DATA:
                get_next = ST_ACK_DATA;
            ST_ACK_CTRL:
                ack_next = ctrl_q[0] ? ST_SEND_DATA : ST_GET_ADDR;
            ST_ACK_ADDR:
                ack_next = ST_GET_DATA;
            default:
                ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol state and line drive
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            data_pull <= 1'b0;
            req_q     <= 1'b0;
            rd_wait   <= 1'b0;
        end
        else
        begin
            rd_wait <= mem.gnt && !we_q;
            if (mem.gnt)
                req_q <= 1'b0;
            else if (rd_launch || wr_launch)
                req_q <= 1'b1;

            if (start_det)
            begin
                state   <= ST_GET_CTRL;
                bit_cnt <= '0;
            end
            else if (stop_det)
                state <= ST_IDLE;
            else
            begin
                case (state)
                    ST_GET_CTRL, ST_GET_ADDR, ST_GET_DATA:
                        if (scl_rise)
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= get_next;
                        end
                    // First fall pulls for the ninth clock, second fall releases
                    ST_ACK_CTRL, ST_ACK_ADDR, ST_ACK_DATA:
                        if (scl_fall)
                        begin
                            if (!data_pull)
                                data_pull <= 1'b1;
                            else
                            begin
                                state     <= ack_next;
                                bit_cnt   <= '0;
                                data_pull <= (ack_next == ST_SEND_DATA) ? !send_q[7] : 1'b0;
                            end
                        end
                    ST_SEND_DATA:
                        if (scl_fall)
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                data_pull <= 1'b0;
                                state     <= ST_WAIT_MACK;
                            end
                            else
                                data_pull <= !send_q[6];
                        end
                    ST_WAIT_MACK:
                        if (scl_rise)
                            state <= data_s ? ST_IDLE : ST_IGNORE;
                    ST_IDLE, ST_IGNORE:
                        ;
                    default:
                        state <= ST_IDLE;
                endcase
            end
        end
    end

    // Byte capture and transmit shifter
    always_ff @(posedge sda)
    begin
        if (scl_rise)
            shift_q <= byte_in;
        if (ctrl_hit)
            ctrl_q <= byte_in;
        if (byte_done && (state == ST_GET_ADDR))
            word_addr <= byte_in;
        if (byte_done && (state == ST_GET_DATA))
            wdata_q <= byte_in;
        if (rd_launch)
            we_q <= 1'b0;
        else if (wr_launch)
            we_q <= 1'b1;
        if (rd_wait)
            send_q <= mem.rdata;
        else if (scl_fall && (state == ST_SEND_DATA))
            send_q <= {send_q[6:0], 1'b0};
    end

    a_pull_on_fall: assert property (@(posedge sda)
        $changed(data_pull) |-> $past(scl_fall) || !$past(rst_n));

endmodule

`default_nettype wire

// ==== rtl/host_mem_port.sv ====
`default_nettype none

module host_mem_port (
    input  logic                  sda,
    input  logic                  rst_n,
    input  logic                  host_rd,
    input  logic                  host_wr,
    input  eeprom_pkg::mem_addr_t host_addr,
    input  eeprom_pkg::mem_data_t host_wdata,
    output logic                  host_done,
    output eeprom_pkg::mem_data_t host_rdata,
    mem_port_if.requester         mem
);

    import eeprom_pkg::*;

    logic      req_q;
    logic      rd_wait;
    logic      we_q;
    logic      accept;
    mem_addr_t addr_q;
    mem_data_t wdata_q;

    // New strobes only count when nothing is in flight
    assign accept = !req_q && !rd_wait && (host_rd || host_wr);

    assign mem.req   = req_q;
    assign mem.we    = we_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            req_q     <= 1'b0;
            rd_wait   <= 1'b0;
            host_done <= 1'b0;
        end
        else
        begin
            rd_wait   <= mem.gnt && !we_q;
            host_done <= (mem.gnt && we_q) || rd_wait;
            if (mem.gnt)
                req_q <= 1'b0;
            else if (accept)
                req_q <= 1'b1;
        end
    end

    always_ff @(posedge sda)
    begin
        if (accept)
        begin
            we_q    <= host_wr;
            addr_q  <= host_addr;
            wdata_q <= host_wdata;
        end
        if (rd_wait)
            host_rdata <= mem.rdata;
    end

    a_one_strobe: assert property (@(posedge sda) disable iff (!rst_n)
        !(host_rd && host_wr));

endmodule

`default_nettype wire

// ==== rtl/eeprom_array_arb.sv ====
`default_nettype none

`include "eeprom_params.svh"

module eeprom_array_arb (
    input  logic        sda,
    input  logic        rst_n,
    mem_port_if.arbiter ser,
    mem_port_if.arbiter hst
);

    import eeprom_pkg::*;

    mem_data_t            mem_q [`EE_DEPTH];
    logic [`EE_ADDR_W:0]  sweep_cnt;
    logic                 sweep_done;
    logic                 ser_take;
    logic                 hst_take;
    logic                 ser_gnt_q;
    logic                 hst_gnt_q;
    logic                 acc_we;
    arb_owner_t           cur_owner;
    arb_owner_t           rd_owner;
    mem_addr_t            acc_addr;
    mem_data_t            acc_wdata;
    mem_data_t            rd_q;

    assign sweep_done = (sweep_cnt == (`EE_ADDR_W+1)'(`EE_DEPTH));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed priority, serial first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A port still holds req during its grant cycle so skip it once
    assign ser_take = sweep_done && ser.req && !ser_gnt_q;
    assign hst_take = sweep_done && hst.req && !hst_gnt_q && !ser_take;

    assign cur_owner = ser_gnt_q ? OWN_SERIAL : OWN_HOST;
    assign acc_addr  = (cur_owner == OWN_SERIAL) ? ser.addr : hst.addr;
    assign acc_wdata = (cur_owner == OWN_SERIAL) ? ser.wdata : hst.wdata;
    assign acc_we    = (ser_gnt_q && ser.we) || (hst_gnt_q && hst.we);

    assign ser.gnt   = ser_gnt_q;
    assign hst.gnt   = hst_gnt_q;
    assign ser.rdata = (rd_owner == OWN_SERIAL) ? rd_q : '0;
    assign hst.rdata = (rd_owner == OWN_HOST) ? rd_q : '0;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            sweep_cnt <= '0;
            ser_gnt_q <= 1'b0;
            hst_gnt_q <= 1'b0;
            rd_owner  <= OWN_SERIAL;
        end
        else
        begin
            if (!sweep_done)
                sweep_cnt <= sweep_cnt + 1'b1;
            ser_gnt_q <= ser_take;
            hst_gnt_q <= hst_take;
            if (ser_gnt_q || hst_gnt_q)
                rd_owner <= cur_owner;
        end
    end

    // Storage with zero fill after reset
    always_ff @(posedge sda)
    begin
        if (!sweep_done)
            mem_q[sweep_cnt[`EE_ADDR_W-1:0]] <= '0;
        else if (acc_we)
            mem_q[acc_addr] <= acc_wdata;
        if (ser_gnt_q || hst_gnt_q)
            rd_q <= mem_q[acc_addr];
    end

    a_one_grant: assert property (@(posedge sda) disable iff (!rst_n)
        !(ser.gnt && hst.gnt));

endmodule

`default_nettype wire

// ==== rtl/eeprom_top.sv ====
`default_nettype none

module eeprom_top (
    input  logic                  sda,
    input  logic                  rst_n,
    input  logic                  scl,
    input  logic                  data_in,
    output logic                  data_pull,
    input  logic                  host_rd,
    input  logic                  host_wr,
    input  eeprom_pkg::mem_addr_t host_addr,
    input  eeprom_pkg::mem_data_t host_wdata,
    output logic                  host_done,
    output eeprom_pkg::mem_data_t host_rdata
);

    logic data_s;
    logic scl_rise;
    logic scl_fall;
    logic start_det;
    logic stop_det;

    mem_port_if ser_mem ();
    mem_port_if hst_mem ();

    bus_line_sync u_sync (
        .sda       (sda),
        .rst_n     (rst_n),
        .scl       (scl),
        .data_in   (data_in),
        .scl_s     (),
        .data_s    (data_s),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det)
    );

    serial_slave_fsm u_slave (
        .sda       (sda),
        .rst_n     (rst_n),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .data_s    (data_s),
        .start_det (start_det),
        .stop_det  (stop_det),
        .data_pull (data_pull),
        .mem       (ser_mem.requester)
    );

    host_mem_port u_host (
        .sda        (sda),
        .rst_n      (rst_n),
        .host_rd    (host_rd),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_done  (host_done),
        .host_rdata (host_rdata),
        .mem        (hst_mem.requester)
    );

    eeprom_array_arb u_array (
        .sda   (sda),
        .rst_n (rst_n),
        .ser   (ser_mem.arbiter),
        .hst   (hst_mem.arbiter)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic sda,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        sda = 1'b0;
        forever #2 sda = ~sda;
    end

    // Reset held low across three rising edges, released on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (3) @(posedge sda);
        @(negedge sda);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_eeprom_top.sv ====
`default_nettype none

`include "eeprom_params.svh"

module tb_eeprom_top;

    timeunit 1ns;
    timeprecision 100ps;

    import eeprom_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'hbc18_4113;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int HOST_OPS         = 4;
    localparam int LAST_OP          = HOST_OPS - 1;
    localparam int HOST_WAIT_CYCLES = 64;
    // scl fall that opens the ACK clock of a write's data byte
    localparam int DATA_ACK_FALL    = 27;
    // 4 + 1 + 2 + 2 byte writes and 3 random reads
    localparam int WR_TXNS     = 9;
    localparam int RD_TXNS     = 3;
    localparam int SERIAL_BITS = WR_TXNS * 30 + RD_TXNS * 40;
    // Margin covers the zero sweep, host traffic and the full readback
    localparam int TIMEOUT_CYCLES = SERIAL_BITS * 20 + 8 * `EE_DEPTH + 4000;

    logic        sda;
    logic        rst_n;
    logic        scl;
    logic        data_in;
    logic        data_pull;
    logic        host_rd;
    logic        host_wr;
    mem_addr_t   host_addr;
    mem_data_t   host_wdata;
    logic        host_done;
    mem_data_t   host_rdata;
    logic        master_drv;
    logic        activity_started;
    logic        host_busy;
    logic        ignore_window;
    logic [31:0] lfsr_q;
    mem_data_t   ref_mem [`EE_DEPTH];

    tb_clock u_clock (
        .sda   (sda),
        .rst_n (rst_n)
    );

    eeprom_top u_dut (
        .sda        (sda),
        .rst_n      (rst_n),
        .scl        (scl),
        .data_in    (data_in),
        .data_pull  (data_pull),
        .host_rd    (host_rd),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_done  (host_done),
        .host_rdata (host_rdata)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial bus master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Wired-AND line: low when the master drives low or the slave pulls
    task automatic bus_step(input logic scl_v, input logic drv, input int n);
        repeat (n)
        begin
            @(negedge sda);
            master_drv = drv;
            scl        = scl_v;
            data_in    = drv && !data_pull;
        end
    endtask

    task automatic bus_bit(input logic drv, output logic line);
        bus_step(1'b0, master_drv, 4);
        bus_step(1'b0, drv, 4);
        bus_step(1'b1, drv, 4);
        line = drv && !data_pull;
        bus_step(1'b1, drv, 4);
    endtask

    task automatic bus_start();
        activity_started = 1'b1;
        bus_step(1'b1, 1'b1, 8);
        bus_step(1'b1, 1'b0, 8);
    endtask

    task automatic bus_restart();
        bus_step(1'b0, master_drv, 4);
        bus_step(1'b0, 1'b1, 4);
        bus_start();
    endtask

    task automatic bus_stop();
        bus_step(1'b0, master_drv, 4);
        bus_step(1'b0, 1'b0, 4);
        bus_step(1'b1, 1'b0, 8);
        bus_step(1'b1, 1'b1, 8);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic exp_ack, input string what);
        logic line;
        for (int i = 7; i >= 0; i--)
            bus_bit(b[i], line);
        bus_bit(1'b1, line);
        assert (!line == exp_ack)
        else
            stop_on_error($sformatf("MISMATCH data_pull ack on %s got=%h exp=%h",
                                    what, !line, exp_ack));
    endtask

    // Master answers with NACK after the byte
    task automatic recv_byte(output logic [7:0] b);
        logic line;
        for (int i = 7; i >= 0; i--)
        begin
            bus_bit(1'b1, line);
            b[i] = line;
        end
        bus_bit(1'b1, line);
    endtask

    task automatic serial_write(input logic [2:0] blk, input logic [7:0] wa,
                                input mem_data_t d);
        bus_start();
        send_byte({`EE_DEV_TYPE, blk, 1'b0}, 1'b1, "control byte");
        send_byte(wa, 1'b1, "word address");
        send_byte(d, 1'b1, "data byte");
        bus_stop();
        ref_mem[{blk, wa}] = d;
    endtask

    task automatic serial_read(input logic [2:0] blk, input logic [7:0] wa,
                               output mem_data_t d);
        bus_start();
        send_byte({`EE_DEV_TYPE, blk, 1'b0}, 1'b1, "write control byte");
        send_byte(wa, 1'b1, "word address");
        bus_restart();
        send_byte({`EE_DEV_TYPE, blk, 1'b1}, 1'b1, "read control byte");
        recv_byte(d);
        bus_stop();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic host_access(input logic wr, input mem_addr_t a, input mem_data_t wd,
                               output mem_data_t rd);
        int waited;
        @(negedge sda);
        host_busy  = 1'b1;
        host_addr  = a;
        host_wdata = wd;
        host_wr    = wr;
        host_rd    = !wr;
        @(negedge sda);
        host_wr = 1'b0;
        host_rd = 1'b0;
        waited  = 0;
        while (!host_done && waited < HOST_WAIT_CYCLES)
        begin
            @(negedge sda);
            waited++;
        end
        if (!host_done)
            stop_on_error($sformatf("host %s at address %h never signalled done",
                                    wr ? "write" : "read", a));
        rd = host_rdata;
        if (wr)
            ref_mem[a] = wd;
        @(negedge sda);
        host_busy = 1'b0;
    endtask

    task automatic host_read_expect(input mem_addr_t a, input mem_data_t exp);
        mem_data_t got;
        host_access(1'b0, a, '0, got);
        assert (got == exp)
        else
            stop_on_error($sformatf("MISMATCH host_rdata addr=%h got=%h exp=%h",
                                    a, got, exp));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    quiet_after_reset: assert property (@(posedge sda) disable iff (!rst_n)
        !activity_started |-> (!data_pull && !host_done))
    else
        stop_on_error($sformatf("MISMATCH data_pull=%h host_done=%h before any transaction",
                                data_pull, host_done));

    silent_when_ignored: assert property (@(posedge sda) disable iff (!rst_n)
        ignore_window |-> !data_pull)
    else
        stop_on_error($sformatf("MISMATCH data_pull=%h exp=0 after foreign control byte",
                                data_pull));

    done_only_when_asked: assert property (@(posedge sda) disable iff (!rst_n)
        host_done |-> host_busy)
    else
        stop_on_error($sformatf("MISMATCH host_done=%h with no host access pending",
                                host_done));

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge sda);
        stop_on_error($sformatf("watchdog expired after %0d cycles", TIMEOUT_CYCLES));
    end

    initial
    begin
        mem_addr_t  a;
        mem_data_t  d;
        mem_data_t  d_alt;
        mem_data_t  got;
        logic [2:0] blk;
        logic [2:0] blk_alt;
        logic [7:0] wa;
        logic [3:0] bad_type;
        logic       op_wr [HOST_OPS];
        mem_addr_t  op_addr [HOST_OPS];
        mem_data_t  op_data [HOST_OPS];
        int         op_gap [HOST_OPS];

        scl              = 1'b1;
        data_in          = 1'b1;
        master_drv       = 1'b1;
        host_rd          = 1'b0;
        host_wr          = 1'b0;
        host_addr        = '0;
        host_wdata       = '0;
        activity_started = 1'b0;
        host_busy        = 1'b0;
        ignore_window    = 1'b0;
        lfsr_q           = LFSR_SEED;
        for (int i = 0; i < `EE_DEPTH; i++)
            ref_mem[i] = '0;

        // Idle through reset and the array's zero sweep
        @(posedge rst_n);
        repeat (`EE_DEPTH + 64) @(negedge sda);

        // Serial byte writes read back by the host
        repeat (4)
        begin
            blk = 3'(lfsr_bits(3));
            wa  = 8'(lfsr_bits(8));
            d   = 8'(lfsr_bits(8));
            serial_write(blk, wa, d);
            host_read_expect({blk, wa}, d);
        end

        // Host writes fetched by serial random reads
        repeat (3)
        begin
            a = 11'(lfsr_bits(11));
            d = 8'(lfsr_bits(8));
            host_access(1'b1, a, d, got);
            serial_read(a[10:8], a[7:0], got);
            assert (got == d)
            else
                stop_on_error($sformatf("MISMATCH serial read data addr=%h got=%h exp=%h",
                                        a, got, d));
        end

        // Foreign device type leaves the array alone
        blk      = 3'(lfsr_bits(3));
        wa       = 8'(lfsr_bits(8));
        d        = 8'(lfsr_bits(8));
        bad_type = 4'(lfsr_bits(4));
        if (bad_type == `EE_DEV_TYPE)
            bad_type = bad_type ^ 4'b0100;
        host_access(1'b1, {blk, wa}, d, got);
        ignore_window = 1'b1;
        bus_start();
        send_byte({bad_type, blk, 1'b0}, 1'b0, "foreign control byte");
        send_byte(wa, 1'b0, "ignored word address");
        send_byte(~d, 1'b0, "ignored data byte");
        bus_stop();
        ignore_window = 1'b0;
        host_read_expect({blk, wa}, d);

        // Same word address under two block selects
        wa      = 8'(lfsr_bits(8));
        blk     = 3'(lfsr_bits(3));
        blk_alt = blk ^ 3'b101;
        d       = 8'(lfsr_bits(8));
        d_alt   = 8'(lfsr_bits(8));
        if (d_alt == d)
            d_alt = ~d;
        serial_write(blk, wa, d);
        serial_write(blk_alt, wa, d_alt);
        host_read_expect({blk, wa}, d);
        host_read_expect({blk_alt, wa}, d_alt);

        // Host traffic while a serial write is on the bus
        repeat (2)
        begin
            blk = 3'(lfsr_bits(3));
            wa  = 8'(lfsr_bits(8));
            d   = 8'(lfsr_bits(8));
            for (int i = 0; i < HOST_OPS; i++)
            begin
                op_wr[i]   = lfsr_bits(1) != 0;
                op_addr[i] = 11'(lfsr_bits(11));
                if (op_addr[i] == {blk, wa})
                    op_addr[i] = op_addr[i] ^ 11'h001;
                op_data[i] = 8'(lfsr_bits(8));
                op_gap[i]  = 60 + int'(lfsr_bits(5));
            end
            fork
                serial_write(blk, wa, d);
                begin
                    for (int i = 0; i < LAST_OP; i++)
                    begin
                        repeat (op_gap[i]) @(negedge sda);
                        if (op_wr[i])
                            host_access(1'b1, op_addr[i], op_data[i], got);
                        else
                            host_read_expect(op_addr[i], ref_mem[op_addr[i]]);
                    end
                end
                // Last host request reaches the arbiter together with the serial write
                begin
                    repeat (DATA_ACK_FALL) @(negedge scl);
                    repeat (`EE_SYNC_STAGES) @(negedge sda);
                    if (op_wr[LAST_OP])
                        host_access(1'b1, op_addr[LAST_OP], op_data[LAST_OP], got);
                    else
                        host_read_expect(op_addr[LAST_OP], ref_mem[op_addr[LAST_OP]]);
                end
            join
        end

        // Whole array against the reference
        for (int i = 0; i < `EE_DEPTH; i++)
            host_read_expect(11'(i), ref_mem[i]);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/eeprom_pkg.sv
rtl/mem_port_if.sv
rtl/bus_line_sync.sv
rtl/serial_slave_fsm.sv
rtl/host_mem_port.sv
rtl/eeprom_array_arb.sv
rtl/eeprom_top.sv
verif/tb_clock.sv
verif/tb_eeprom_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the EEPROM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_top \
    -f files.f

./obj_dir/Vtb_eeprom_top
